//--- gbe_tx_cases.txt
// cases: mode (0 words listed, 1 random words), pkt_len, sleep_cycles, dest ip, dest port,
// word count, then the words of a mode 0 case. the first value is the number of cases.
7

// listed words, 4 byte packets, gap of 3.
0 4 3 c0a80001 1f90 4
01020304 05060708 090a0b0c 0d0e0f10

// single byte packets, no gap.
0 1 0 0a000002 0035 3
deadbeef 00ff00ff 80000001

// 7 byte packets leave a partial packet at the end.
0 7 0 7f000001 ffff 2
a5a5a5a5 5a5a5a5a

// random words, 7 byte packets, gap of 20.
1 7 14 ac100005 d431 a

// random words, a full fifo of them, no gap.
1 4 0 c0a80a0a 1388 10

// random words, 7 byte packets, gap of 3.
1 7 3 0a0a0a0a 04d2 8

// overflow: 20 words while the long gap holds the packetizer off.
1 4 c8 c0a80064 c350 14

//--- filelist.f
gbe_net_pkg.sv
gbe_stream_pkg.sv
sync_fifo.sv
piso.sv
gbe_write_packetizer.sv
gbe_tx_top.sv
gbe_tx_chk.sv
gbe_tx_tb.sv

//--- run.sh
#!/bin/sh
# build and run the gbe tx testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module gbe_tx_tb -o gbe_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/gbe_tx_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

//--- gbe_tx_tb.sv
`timescale 1ns/100ps

module gbe_tx_tb;

    localparam int DIN_WIDTH  = 32;
    localparam int FIFO_DEPTH = 16;
    localparam int N_BYTES    = DIN_WIDTH / 8;

    logic                   clk;
    logic                   rst;
    logic [DIN_WIDTH-1:0]   din;
    logic                   din_valid;
    gbe_net_pkg::count_t    pkt_len;
    gbe_net_pkg::count_t    sleep_cycles;
    gbe_net_pkg::ip_addr_t  config_tx_dest_ip;
    gbe_net_pkg::udp_port_t config_tx_dest_port;
    gbe_stream_pkg::byte_t  tx_data;
    logic                   tx_valid;
    gbe_net_pkg::ip_addr_t  tx_dest_ip;
    gbe_net_pkg::udp_port_t tx_dest_port;
    logic                   tx_eof;
    logic                   fifo_full;

    logic [31:0] cases_mem [0:255];
    logic [31:0] rng_state;
    int          case_ptr;  // next unread value of the case file.

    // monitor state of the running case.
    gbe_stream_pkg::byte_t  exp_q [$];
    gbe_net_pkg::ip_addr_t  cur_ip;
    gbe_net_pkg::udp_port_t cur_port;
    int                     cur_case;
    int                     got;
    int                     pkt_cnt;
    int                     gap;
    int                     case_errors;
    logic                   after_eof;
    logic                   saw_full;
    logic                   timed_out;

    int total_errors;
    int cases_passed;
    int cases_failed;

    gbe_tx_top #(
        .DIN_WIDTH  (DIN_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .din                 (din),
        .din_valid           (din_valid),
        .pkt_len             (pkt_len),
        .sleep_cycles        (sleep_cycles),
        .config_tx_dest_ip   (config_tx_dest_ip),
        .config_tx_dest_port (config_tx_dest_port),
        .tx_data             (tx_data),
        .tx_valid            (tx_valid),
        .tx_dest_ip          (tx_dest_ip),
        .tx_dest_port        (tx_dest_port),
        .tx_eof              (tx_eof),
        .fifo_full           (fifo_full)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail %s expected %h got %h in case %0d", name, expected, actual, cur_case);
        case_errors++;
    endtask

    // samples the tx outputs on the falling edge.
    task automatic check_outputs();
        gbe_stream_pkg::byte_t exp_byte;
        logic                  exp_eof;
        if (fifo_full === 1'b1) begin
            saw_full = 1'b1;
        end
        if (tx_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("case %0d: byte %h arrived when none was expected", cur_case, tx_data);
                case_errors++;
            end else begin
                exp_byte = exp_q.pop_front();
                if (tx_data !== exp_byte) begin
                    report_mismatch("tx_data", {24'h0, exp_byte}, {24'h0, tx_data});
                end
            end
            got++;
            pkt_cnt++;
            exp_eof = (pkt_cnt == int'(pkt_len));  // last byte of a packet.
            if (tx_eof !== exp_eof) begin
                report_mismatch("tx_eof", {31'h0, exp_eof}, {31'h0, tx_eof});
            end
            if (exp_eof) begin
                pkt_cnt = 0;
            end
            if (after_eof && gap < int'(sleep_cycles)) begin
                $display("case %0d: only %0d idle cycles after end of frame, %0d required",
                         cur_case, gap, sleep_cycles);
                case_errors++;
            end
            if (tx_dest_ip !== cur_ip) begin
                report_mismatch("tx_dest_ip", cur_ip, tx_dest_ip);
            end
            if (tx_dest_port !== cur_port) begin
                report_mismatch("tx_dest_port", {16'h0, cur_port}, {16'h0, tx_dest_port});
            end
            after_eof = tx_eof;
            gap       = 0;
        end else begin
            if (tx_eof !== 1'b0) begin
                report_mismatch("tx_eof", 32'h0, {31'h0, tx_eof});
            end
            gap++;
        end
    endtask

    task automatic run_case(input int idx);
        logic [31:0] mode;
        logic [31:0] words [$];
        logic [31:0] w;
        int          n_words;
        int          i;
        int          b;
        int          fifo_cnt;
        int          dropped;
        int          sent;
        int          cyc;
        int          limit;
        int          n_exp;
        logic        held;
        logic        rd_now;

        cur_case    = idx;
        case_errors = 0;
        got         = 0;
        pkt_cnt     = 0;
        gap         = 0;
        after_eof   = 1'b0;
        saw_full    = 1'b0;
        mode        = cases_mem[case_ptr];
        cur_ip      = cases_mem[case_ptr+3];
        cur_port    = cases_mem[case_ptr+4][15:0];
        n_words     = int'(cases_mem[case_ptr+5]);

        @(posedge clk);
        rst                 <= 1'b1;
        din_valid           <= 1'b0;
        pkt_len             <= cases_mem[case_ptr+1];
        sleep_cycles        <= cases_mem[case_ptr+2];
        config_tx_dest_ip   <= cur_ip;
        config_tx_dest_port <= cur_port;

        for (i = 0; i < n_words; i++) begin
            if (mode == 32'd0) begin
                w = cases_mem[case_ptr+6+i];
            end else begin
                rng_state = next_random(rng_state);
                w         = rng_state;
            end
            words.push_back(w);
        end
        case_ptr = case_ptr + 6 + ((mode == 32'd0) ? n_words : 0);

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // expected bytes for one word per cycle into the fifo.
        // the serializer takes the head word a cycle after it shows up.
        exp_q.delete();
        fifo_cnt = 0;
        dropped  = 0;
        held     = 1'b0;
        for (i = 0; i < n_words; i++) begin
            rd_now = (fifo_cnt > 0) && !held;
            if (fifo_cnt == FIFO_DEPTH) begin
                dropped++;  // write lost to a full fifo.
            end else begin
                fifo_cnt++;
                for (b = N_BYTES - 1; b >= 0; b--) begin
                    exp_q.push_back(words[i][b*8 +: 8]);  // msb first.
                end
            end
            if (rd_now) begin
                fifo_cnt--;
                held = 1'b1;
            end
        end

        @(negedge clk);
        if (tx_valid !== 1'b0) report_mismatch("tx_valid", 32'h0, {31'h0, tx_valid});
        if (tx_eof !== 1'b0) report_mismatch("tx_eof", 32'h0, {31'h0, tx_eof});
        if (fifo_full !== 1'b0) report_mismatch("fifo_full", 32'h0, {31'h0, fifo_full});

        n_exp = exp_q.size();
        limit = n_words * N_BYTES * (int'(sleep_cycles) + 8) + 200;
        sent  = 0;
        cyc   = 0;
        while ((sent < n_words || got < n_exp) && cyc < limit) begin
            @(posedge clk);
            if (sent < n_words) begin
                din       <= words[sent];
                din_valid <= 1'b1;
                sent++;
            end else begin
                din_valid <= 1'b0;
            end
            @(negedge clk);
            check_outputs();
            cyc++;
        end
        @(posedge clk);
        din_valid <= 1'b0;

        if (cyc >= limit) begin
            $display("case %0d: timeout after %0d cycles, %0d of %0d bytes received",
                     idx, cyc, got, n_exp);
            timed_out = 1'b1;
            case_errors++;
            total_errors += case_errors;
            cases_failed++;
        end else begin
            repeat (8) begin
                @(negedge clk);
                check_outputs();  // stray bytes after the last one.
            end
            if (dropped > 0 && !saw_full) begin
                $display("case %0d: fifo_full never rose with %0d words lost", idx, dropped);
                case_errors++;
            end
            if (dropped == 0 && saw_full) begin
                $display("case %0d: fifo_full rose although every word fit", idx);
                case_errors++;
            end
            if (exp_q.size() != 0) begin
                $display("case %0d: %0d expected bytes never arrived", idx, exp_q.size());
                case_errors++;
            end
            total_errors += case_errors;
            if (case_errors == 0) begin
                cases_passed++;
                $display("case %0d ok: %0d bytes, %0d words dropped", idx, got, dropped);
            end else begin
                cases_failed++;
                $display("case %0d failed with %0d errors", idx, case_errors);
            end
        end
    endtask

    initial begin
        int n_cases;
        int c;
        clk                 = 1'b0;
        rst                 = 1'b1;
        din                 = '0;
        din_valid           = 1'b0;
        pkt_len             = 32'd1;
        sleep_cycles        = '0;
        config_tx_dest_ip   = '0;
        config_tx_dest_port = '0;
        rng_state           = 32'hd8c1;
        timed_out           = 1'b0;
        total_errors        = 0;
        cases_passed        = 0;
        cases_failed        = 0;

        $readmemh("gbe_tx_cases.txt", cases_mem);
        n_cases  = int'(cases_mem[0]);
        case_ptr = 1;
        for (c = 1; c <= n_cases && !timed_out; c++) begin
            run_case(c);
        end

        total_errors += dut0.chk0.fail_count;
        $display("%0d cases ok, %0d cases failed, %0d errors, %0d assertion failures",
                 cases_passed, cases_failed, total_errors, dut0.chk0.fail_count);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- gbe_tx_chk.sv
`timescale 1ns/100ps

module gbe_tx_chk (
    input logic                       clk,
    input logic                       rst,
    input logic                       tx_valid,
    input logic                       tx_eof,
    input logic                       piso_valid,
    input gbe_stream_pkg::byte_t      piso_data,
    input gbe_stream_pkg::pkt_state_t state
);

    int fail_count = 0;  // assertion failures so far.

    // end of frame only rides on a valid byte.
    a_eof_valid: assert property (@(posedge clk) disable iff (rst) tx_eof |-> tx_valid)
        else begin
            $error("tx_eof high without tx_valid");
            fail_count++;
        end

    a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(tx_valid))
        else begin
            $error("tx_valid unknown after reset");
            fail_count++;
        end

    // the serializer is held off during the idle gap.
    a_hold_wait: assert property (@(posedge clk) disable iff (rst)
        (state == gbe_stream_pkg::st_wait) && piso_valid
            |=> piso_valid && $stable(piso_data))
        else begin
            $error("serializer advanced in st_wait");
            fail_count++;
        end

endmodule

bind gbe_tx_top gbe_tx_chk chk0 (
    .clk        (clk),
    .rst        (rst),
    .tx_valid   (tx_valid),
    .tx_eof     (tx_eof),
    .piso_valid (packetizer0.piso_valid),
    .piso_data  (packetizer0.piso_data),
    .state      (packetizer0.state)
);

//--- gbe_tx_top.sv
`timescale 1ns/100ps

module gbe_tx_top #(
    parameter int DIN_WIDTH  = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [DIN_WIDTH-1:0]      din,
    input  logic                      din_valid,
    input  gbe_net_pkg::count_t       pkt_len,
    input  gbe_net_pkg::count_t       sleep_cycles,
    input  gbe_net_pkg::ip_addr_t     config_tx_dest_ip,
    input  gbe_net_pkg::udp_port_t    config_tx_dest_port,
    output gbe_stream_pkg::byte_t     tx_data,
    output logic                      tx_valid,
    output gbe_net_pkg::ip_addr_t     tx_dest_ip,
    output gbe_net_pkg::udp_port_t    tx_dest_port,
    output logic                      tx_eof,
    output logic                      fifo_full
);

    // transmit streamer, fifo and serializer sit below the packetizer.
    gbe_write_packetizer #(
        .DIN_WIDTH  (DIN_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) packetizer0 (
        .clk                 (clk),
        .rst                 (rst),
        .din                 (din),
        .din_valid           (din_valid),
        .pkt_len             (pkt_len),
        .sleep_cycles        (sleep_cycles),
        .config_tx_dest_ip   (config_tx_dest_ip),
        .config_tx_dest_port (config_tx_dest_port),
        .tx_data             (tx_data),
        .tx_valid            (tx_valid),
        .tx_dest_ip          (tx_dest_ip),
        .tx_dest_port        (tx_dest_port),
        .tx_eof              (tx_eof),
        .fifo_full           (fifo_full)
    );

endmodule

//--- gbe_write_packetizer.sv
`timescale 1ns/100ps

module gbe_write_packetizer #(
    parameter int DIN_WIDTH  = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [DIN_WIDTH-1:0]      din,
    input  logic                      din_valid,
    input  gbe_net_pkg::count_t       pkt_len,
    input  gbe_net_pkg::count_t       sleep_cycles,
    input  gbe_net_pkg::ip_addr_t     config_tx_dest_ip,
    input  gbe_net_pkg::udp_port_t    config_tx_dest_port,
    output gbe_stream_pkg::byte_t     tx_data,
    output logic                      tx_valid,
    output gbe_net_pkg::ip_addr_t     tx_dest_ip,
    output gbe_net_pkg::udp_port_t    tx_dest_port,
    output logic                      tx_eof,
    output logic                      fifo_full
);

    gbe_stream_pkg::byte_t      piso_data;
    logic                       piso_valid;
    logic                       dout_ready;
    logic                       byte_take;
    gbe_stream_pkg::pkt_state_t state;
    gbe_net_pkg::count_t        counter;
    gbe_stream_pkg::byte_t      data_q;
    logic                       valid_q;
    logic                       eof_q;

    // the word has to split into whole bytes.
    if (DIN_WIDTH % gbe_stream_pkg::BYTE_WIDTH != 0) begin : g_width_check
        $error("DIN_WIDTH must be a multiple of the byte width");
    end

    piso #(
        .DIN_WIDTH  (DIN_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) piso0 (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .dout       (piso_data),
        .dout_valid (piso_valid),
        .dout_ready (dout_ready),
        .fifo_full  (fifo_full)
    );

    assign dout_ready = (state == gbe_stream_pkg::st_read);
    assign byte_take  = piso_valid & dout_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= gbe_stream_pkg::st_wait;
            counter <= '0;
            valid_q <= 1'b0;
            eof_q   <= 1'b0;
        end else begin
            case (state)
                gbe_stream_pkg::st_wait: begin
                    valid_q <= 1'b0;  // eof byte clears here.
                    eof_q   <= 1'b0;
                    // idle gap of sleep_cycles, one cycle at the least.
                    if (counter + 1 >= sleep_cycles) begin
                        counter <= '0;
                        state   <= gbe_stream_pkg::st_read;
                    end else begin
                        counter <= counter + 1;
                    end
                end
                gbe_stream_pkg::st_read: begin
                    valid_q <= byte_take;  // stalls when piso runs dry.
                    eof_q   <= 1'b0;
                    if (byte_take) begin
                        if (counter + 1 == pkt_len) begin
                            eof_q   <= 1'b1;  // last byte of the packet.
                            counter <= '0;
                            state   <= gbe_stream_pkg::st_wait;
                        end else begin
                            counter <= counter + 1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_take) begin
            data_q <= piso_data;
        end
    end

    assign tx_data      = data_q;
    assign tx_valid     = valid_q;
    assign tx_eof       = eof_q;
    assign tx_dest_ip   = config_tx_dest_ip;    // static configuration.
    assign tx_dest_port = config_tx_dest_port;

endmodule

//--- piso.sv
`timescale 1ns/100ps

module piso #(
    parameter int DIN_WIDTH  = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DIN_WIDTH-1:0]  din,
    input  logic                  din_valid,
    output gbe_stream_pkg::byte_t dout,
    output logic                  dout_valid,
    input  logic                  dout_ready,
    output logic                  fifo_full
);

    localparam int BW      = gbe_stream_pkg::BYTE_WIDTH;
    localparam int N_BYTES = DIN_WIDTH / BW;
    localparam int CNT_W   = $clog2(N_BYTES + 1);

    logic [DIN_WIDTH-1:0] fifo_data;
    logic                 fifo_empty;
    logic                 fifo_rd;
    logic [DIN_WIDTH-1:0] shreg;
    logic [CNT_W-1:0]     bytes_left;
    logic                 take;
    logic                 last_take;

    sync_fifo #(
        .WIDTH (DIN_WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk     (clk),
        .rst     (rst),
        .wr_data (din),
        .wr_en   (din_valid),
        .rd_data (fifo_data),
        .rd_en   (fifo_rd),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    assign take      = dout_valid & dout_ready;
    assign last_take = take & (bytes_left == CNT_W'(1));

    // pop when nothing is held or the last byte goes out this cycle.
    assign fifo_rd = ~fifo_empty & ((bytes_left == '0) | last_take);

    assign dout       = shreg[DIN_WIDTH-1 -: BW];  // msb first.
    assign dout_valid = (bytes_left != '0);

    // byte counter, control state.
    always_ff @(posedge clk) begin
        if (rst) begin
            bytes_left <= '0;
        end else if (fifo_rd) begin
            bytes_left <= CNT_W'(N_BYTES);
        end else if (take) begin
            bytes_left <= bytes_left - 1'b1;
        end
    end

    // shift register holds the word being sent.
    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            shreg <= fifo_data;  // load a fresh word.
        end else if (take) begin
            shreg <= shreg << BW;  // next byte moves to the top.
        end
    end

endmodule

//--- sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_en,
    output logic [WIDTH-1:0] rd_data,
    input  logic             rd_en,
    output logic             empty,
    output logic             full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);

    assign do_wr = wr_en & ~full;   // writes while full are dropped.
    assign do_rd = rd_en & ~empty;

    // first word fall through, the head is always on rd_data.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // wrap by hand so any depth works.
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or read and write together.
            endcase
        end
    end

endmodule

//--- gbe_stream_pkg.sv
package gbe_stream_pkg;

    // datapath definitions for the byte stream.

    localparam int BYTE_WIDTH = 8;  // width of one serialized byte.

    // one byte as it leaves the serializer.
    typedef logic [BYTE_WIDTH-1:0] byte_t;

    // packetizer states.
    // st_wait counts the idle gap, st_read frames bytes into a packet.
    typedef enum logic {
        st_wait = 1'b0,
        st_read = 1'b1
    } pkt_state_t;

endpackage

//--- gbe_net_pkg.sv
package gbe_net_pkg;

    // network side configuration fields.

    localparam int IP_WIDTH    = 32;
    localparam int PORT_WIDTH  = 16;
    localparam int COUNT_WIDTH = 32;

    // destination ipv4 address.
    typedef logic [IP_WIDTH-1:0] ip_addr_t;

    // destination udp port, kept at full width.
    typedef logic [PORT_WIDTH-1:0] udp_port_t;

    // packet length and idle gap counts.
    typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage
